//--- source/istream_pkg.sv
// shared types for the stream buffer; a fetch set is 16-byte aligned, eight parcels wide
`default_nettype none

package istream_pkg;

    // --------------------------------------------------
    // sizes
    localparam int PARCELS_PER_SET = 8;
    localparam int WINDOW          = 2 * PARCELS_PER_SET;
    localparam int WAYS            = 4;

    typedef logic [15:0] parcel_t;

    // address bits above the 16-byte set offset
    typedef logic [27:0] base_t;

    // --------------------------------------------------
    // bundles
    typedef struct packed {
        logic [PARCELS_PER_SET-1:0]    valid;
        parcel_t [PARCELS_PER_SET-1:0] parcels;
        base_t                         after_base;
    } fetch_set_t;

    typedef struct packed {
        logic        valid;
        logic        uncomp;
        parcel_t     lower;
        parcel_t     upper;
        logic [31:0] pc;
    } way_t;

    // set 0 in the low half, set 1 in the high half
    typedef struct packed {
        logic [WINDOW-1:0]    valid;
        logic [WINDOW-1:0]    uncomp;
        parcel_t [WINDOW-1:0] parcels;
        base_t                base0;
        base_t                base1;
    } window_t;

endpackage

`default_nettype wire

//--- source/lsb_picker.sv
// pure combinational; with an empty request every output is zero, including the index
`timescale 1ns/1ns
`default_nettype none

module lsb_picker #(
    parameter int WIDTH = 16
) (
    input  wire logic [WIDTH-1:0]                           req,
    output logic [WIDTH-1:0]                                one_hot,
    output logic [WIDTH-1:0]                                cold,
    output logic [(WIDTH > 1 ? $clog2(WIDTH) : 1)-1:0]      index
);

    localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic found;

    // scan upward, everything past the first hit is cold
    always_comb begin
        one_hot = '0;
        cold    = '0;
        index   = '0;
        found   = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            if (found) begin
                cold[i] = 1'b1;
            end else if (req[i]) begin
                one_hot[i] = 1'b1;
                index      = IDX_W'(i);
                found      = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/set_store.sv
// ISTREAM_SETS must be a power of two and at least 2; only restart_pc[31:4] is kept
`timescale 1ns/1ns
`default_nettype none

module set_store
    import istream_pkg::*;
#(
    parameter int          ISTREAM_SETS = 8,
    parameter logic [31:0] INIT_PC      = 32'h8000_0000
) (
    input  wire logic                   CLK,
    input  wire logic                   nRST,
    input  wire logic                   restart,
    input  wire logic [31:0]            restart_pc,
    input  wire logic                   enq,
    input  wire fetch_set_t             set_in,
    input  wire logic                   retire0,
    input  wire logic                   retire1,
    output parcel_t [WINDOW-1:0]        parcels,
    output base_t                       base0,
    output base_t                       base1,
    output logic                        stall_senq
);

    localparam int IDX_W = $clog2(ISTREAM_SETS);

    typedef struct packed {
        logic             wrap;
        logic [IDX_W-1:0] idx;
    } ptr_t;

    ptr_t enq_ptr;
    ptr_t deq0_ptr;
    ptr_t deq1_ptr;

    parcel_t [PARCELS_PER_SET-1:0] mem_parcels [ISTREAM_SETS];
    base_t                         mem_after   [ISTREAM_SETS];

    // --------------------------------------------------
    // ring storage
    always_ff @(posedge CLK) begin
        if (enq && !restart) begin
            mem_parcels[enq_ptr.idx] <= set_in.parcels;
            mem_after[enq_ptr.idx]   <= set_in.after_base;
        end
    end

    // full when indices meet on different laps
    assign stall_senq = (enq_ptr.idx == deq0_ptr.idx) && (enq_ptr.wrap != deq0_ptr.wrap);

    assign parcels = {mem_parcels[deq1_ptr.idx], mem_parcels[deq0_ptr.idx]};
    assign base1   = mem_after[deq0_ptr.idx];

    // --------------------------------------------------
    // pointers and set 0 base
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            enq_ptr  <= '0;
            deq0_ptr <= '0;
            deq1_ptr <= '{wrap: 1'b0, idx: IDX_W'(1)};
            base0    <= INIT_PC[31:4];
        end else if (restart) begin
            enq_ptr  <= '0;
            deq0_ptr <= '0;
            deq1_ptr <= '{wrap: 1'b0, idx: IDX_W'(1)};
            base0    <= restart_pc[31:4];
        end else begin
            if (enq) begin
                enq_ptr <= enq_ptr + 1'b1;
            end
            // two sets gone, next base follows set 1
            if (retire1) begin
                deq0_ptr <= deq0_ptr + 2'd2;
                deq1_ptr <= deq1_ptr + 2'd2;
                base0    <= mem_after[deq1_ptr.idx];
            end else if (retire0) begin
                deq0_ptr <= deq0_ptr + 1'b1;
                deq1_ptr <= deq1_ptr + 1'b1;
                base0    <= mem_after[deq0_ptr.idx];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/set_tracker.sv
// every enqueued set must carry at least one valid parcel or it never retires
`timescale 1ns/1ns
`default_nettype none

module set_tracker
    import istream_pkg::*;
#(
    parameter int ISTREAM_SETS = 8
) (
    input  wire logic               CLK,
    input  wire logic               nRST,
    input  wire logic               restart,
    input  wire logic               enq,
    input  wire fetch_set_t         set_in,
    input  wire logic [WINDOW-1:0]  ack,
    input  wire logic               retire0,
    input  wire logic               retire1,
    output logic [WINDOW-1:0]       valid_vec,
    output logic [WINDOW-1:0]       uncomp_vec
);

    logic [ISTREAM_SETS-1:0][PARCELS_PER_SET-1:0] valid_q, valid_n;
    logic [ISTREAM_SETS-1:0][PARCELS_PER_SET-1:0] uncomp_q, uncomp_n;
    logic [ISTREAM_SETS-1:0]                      occ_q, occ_n;
    logic [ISTREAM_SETS-1:0]                      free_oh;
    logic [PARCELS_PER_SET-1:0]                   enq_uncomp;
    logic [1:0]                                   shift;

    // low bits 11 mark a 32-bit start
    always_comb begin
        for (int i = 0; i < PARCELS_PER_SET; i++) begin
            enq_uncomp[i] = (set_in.parcels[i][1:0] == 2'b11);
        end
    end

    lsb_picker #(
        .WIDTH(ISTREAM_SETS)
    ) u_free (
        .req(~occ_q),
        .one_hot(free_oh),
        .cold(),
        .index()
    );

    // --------------------------------------------------
    // next state before the retire shift
    always_comb begin
        valid_n  = valid_q;
        uncomp_n = uncomp_q;
        occ_n    = occ_q;
        valid_n[0] = valid_q[0] & ~ack[PARCELS_PER_SET-1:0];
        valid_n[1] = valid_q[1] & ~ack[WINDOW-1:PARCELS_PER_SET];
        for (int s = 0; s < ISTREAM_SETS; s++) begin
            if (enq && free_oh[s]) begin
                valid_n[s]  = set_in.valid;
                uncomp_n[s] = enq_uncomp;
                occ_n[s]    = 1'b1;
            end
        end
    end

    assign shift = retire1 ? 2'd2 : (retire0 ? 2'd1 : 2'd0);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q  <= '0;
            uncomp_q <= '0;
            occ_q    <= '0;
        end else if (restart) begin
            valid_q  <= '0;
            uncomp_q <= '0;
            occ_q    <= '0;
        end else begin
            // compaction keeps the oldest set at slot 0
            valid_q  <= valid_n >> (shift * PARCELS_PER_SET);
            uncomp_q <= uncomp_n >> (shift * PARCELS_PER_SET);
            occ_q    <= occ_n >> shift;
        end
    end

    assign valid_vec  = {valid_q[1], valid_q[0]};
    assign uncomp_vec = {uncomp_q[1], uncomp_q[0]};

endmodule

`default_nettype wire

//--- source/way_select.sv
// combinational only; ack and retire pulses are already zero while stall_sdeq is high
`timescale 1ns/1ns
`default_nettype none

module way_select
    import istream_pkg::*;
(
    input  wire window_t            win,
    input  wire logic               stall_sdeq,
    output way_t [WAYS-1:0]         ways,
    output logic [WINDOW-1:0]       ack,
    output logic                    retire0,
    output logic                    retire1
);

    localparam int IDX_W = $clog2(WINDOW);

    logic [WINDOW-1:0]              marker;
    logic [WAYS-1:0][WINDOW-1:0]    lo_req, lo_oh, lo_cold;
    logic [WAYS-1:0][WINDOW-1:0]    up_req, up_oh;
    logic [WAYS-1:0][IDX_W-1:0]     lo_idx, up_idx;
    logic [WAYS-1:0]                lo_uncomp;
    logic [WAYS-1:0]                way_ok;
    logic [WINDOW-1:0]              ack_raw;
    logic [WINDOW-1:0]              remain;

    // --------------------------------------------------
    // instruction starts
    always_comb begin
        logic pend;
        pend = 1'b0;
        marker = '0;
        for (int i = 0; i < WINDOW; i++) begin
            if (win.valid[i]) begin
                // parcel is the upper half of the previous start
                if (pend) begin
                    pend = 1'b0;
                end else begin
                    marker[i] = 1'b1;
                    pend      = win.uncomp[i];
                end
            end
        end
    end

    // --------------------------------------------------
    // per-way pickers
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        if (w == 0) begin : g_first
            assign lo_req[w] = marker;
        end else begin : g_next
            assign lo_req[w] = lo_req[w-1] & ~lo_oh[w-1];
        end

        // upper half is the first valid parcel past the lower one
        assign up_req[w] = win.valid & lo_cold[w];

        lsb_picker #(
            .WIDTH(WINDOW)
        ) u_lower (
            .req(lo_req[w]),
            .one_hot(lo_oh[w]),
            .cold(lo_cold[w]),
            .index(lo_idx[w])
        );

        lsb_picker #(
            .WIDTH(WINDOW)
        ) u_upper (
            .req(up_req[w]),
            .one_hot(up_oh[w]),
            .cold(),
            .index(up_idx[w])
        );
    end

    // --------------------------------------------------
    // way packing and acknowledgement
    always_comb begin
        ack_raw = '0;
        for (int w = 0; w < WAYS; w++) begin
            lo_uncomp[w] = |(win.uncomp & lo_oh[w]);
            way_ok[w]    = (|lo_req[w]) && (!lo_uncomp[w] || (|up_req[w]));
            ways[w]      = '0;
            if (way_ok[w]) begin
                ack_raw = ack_raw | lo_oh[w];
                if (lo_uncomp[w]) begin
                    ack_raw = ack_raw | up_oh[w];
                end
                ways[w].valid  = 1'b1;
                ways[w].uncomp = lo_uncomp[w];
                ways[w].lower  = win.parcels[lo_idx[w]];
                ways[w].upper  = lo_uncomp[w] ? win.parcels[up_idx[w]] : '0;
                // top index bit picks the set base
                ways[w].pc = {
                    lo_idx[w][IDX_W-1] ? win.base1 : win.base0,
                    lo_idx[w][IDX_W-2:0],
                    1'b0
                };
            end
        end
    end

    assign ack    = stall_sdeq ? '0 : ack_raw;
    assign remain = win.valid & ~ack_raw;

    // set 1 only leaves together with set 0
    assign retire0 = !stall_sdeq
                     && (|win.valid[PARCELS_PER_SET-1:0])
                     && !(|remain[PARCELS_PER_SET-1:0]);
    assign retire1 = retire0
                     && (|win.valid[WINDOW-1:PARCELS_PER_SET])
                     && !(|remain[WINDOW-1:PARCELS_PER_SET]);

endmodule

`default_nettype wire

//--- source/istream.sv
// hold set_senq while stall_senq is high; restart wins over enqueue and dequeue
`timescale 1ns/1ns
`default_nettype none

module istream
    import istream_pkg::*;
#(
    parameter int          ISTREAM_SETS = 8,
    parameter logic [31:0] INIT_PC      = 32'h8000_0000
) (
    input  wire logic           CLK,
    input  wire logic           nRST,
    input  wire logic           valid_senq,
    input  wire fetch_set_t     set_senq,
    output logic                stall_senq,
    output way_t [WAYS-1:0]     ways_sdeq,
    output logic                valid_sdeq,
    input  wire logic           stall_sdeq,
    input  wire logic           restart,
    input  wire logic [31:0]    restart_pc
);

    logic                   enq;
    parcel_t [WINDOW-1:0]   parcels;
    base_t                  base0;
    base_t                  base1;
    logic [WINDOW-1:0]      valid_vec;
    logic [WINDOW-1:0]      uncomp_vec;
    window_t                win;
    logic [WINDOW-1:0]      ack;
    logic                   retire0;
    logic                   retire1;

    assign enq = valid_senq && !stall_senq;

    assign win = '{
        valid:   valid_vec,
        uncomp:  uncomp_vec,
        parcels: parcels,
        base0:   base0,
        base1:   base1
    };

    assign valid_sdeq = ways_sdeq[0].valid;

    // --------------------------------------------------
    set_store #(
        .ISTREAM_SETS(ISTREAM_SETS),
        .INIT_PC(INIT_PC)
    ) u_store (
        .CLK(CLK),
        .nRST(nRST),
        .restart(restart),
        .restart_pc(restart_pc),
        .enq(enq),
        .set_in(set_senq),
        .retire0(retire0),
        .retire1(retire1),
        .parcels(parcels),
        .base0(base0),
        .base1(base1),
        .stall_senq(stall_senq)
    );

    set_tracker #(
        .ISTREAM_SETS(ISTREAM_SETS)
    ) u_tracker (
        .CLK(CLK),
        .nRST(nRST),
        .restart(restart),
        .enq(enq),
        .set_in(set_senq),
        .ack(ack),
        .retire0(retire0),
        .retire1(retire1),
        .valid_vec(valid_vec),
        .uncomp_vec(uncomp_vec)
    );

    way_select u_select (
        .win(win),
        .stall_sdeq(stall_sdeq),
        .ways(ways_sdeq),
        .ack(ack),
        .retire0(retire0),
        .retire1(retire1)
    );

endmodule

`default_nettype wire

//--- tests/istream_checker.sv
// compares issued ways in program order; expected entries are pushed by the testbench
`timescale 1ns/1ns
`default_nettype none

module istream_checker
    import istream_pkg::*;
(
    input  wire logic             CLK,
    input  wire logic             nRST,
    input  wire logic             restart,
    input  wire logic             stall_sdeq,
    input  wire logic             valid_sdeq,
    input  wire way_t [WAYS-1:0]  ways
);

    way_t            exp_q[$];
    way_t [WAYS-1:0] held_ways;
    logic            held           = 1'b0;
    int              mismatch_count = 0;
    int              extra_count    = 0;
    int              missing_count  = 0;

    task automatic push_expected(input logic [31:0] pc, input parcel_t lower,
                                 input parcel_t upper, input logic uncomp);
        way_t e;
        e = '{valid: 1'b1, uncomp: uncomp, lower: lower, upper: upper, pc: pc};
        exp_q.push_back(e);
    endtask

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    task automatic check_drained();
        if (exp_q.size() != 0) begin
            $display("%0d expected instructions were never issued, the first at pc %h",
                     exp_q.size(), exp_q[0].pc);
        end
        missing_count = exp_q.size();
    endtask

    // --------------------------------------------------
    // a consumed cycle takes every valid way, lowest first
    always @(posedge CLK) begin : compare
        way_t e;
        logic shown;
        logic gap;
        if (nRST && !restart) begin
            shown = 1'b0;
            gap   = 1'b0;
            // valid ways fill from way 0 with no hole
            for (int w = 0; w < WAYS; w++) begin
                if (ways[w].valid) begin
                    if (gap) begin
                        $display("error %0t: way %0d valid above an empty way", $time, w);
                        mismatch_count++;
                    end
                    shown = 1'b1;
                end else begin
                    gap = 1'b1;
                end
            end
            if (valid_sdeq !== shown) begin
                $display("error %0t: valid_sdeq %b, want %b", $time, valid_sdeq, shown);
                mismatch_count++;
            end
            // a stalled edge leaves every shown way in place
            if (held) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (held_ways[w].valid && ways[w] !== held_ways[w]) begin
                        $display("error %0t: way %0d changed under stall, pc %h was %h",
                                 $time, w, ways[w].pc, held_ways[w].pc);
                        mismatch_count++;
                    end
                end
            end
            held      = stall_sdeq;
            held_ways = ways;
            if (!stall_sdeq) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (ways[w].valid) begin
                        if (exp_q.size() == 0) begin
                            $display("instruction at pc %h issued beyond the expected list",
                                     ways[w].pc);
                            extra_count++;
                        end else begin
                            e = exp_q.pop_front();
                            if (ways[w] !== e) begin
                                $display("error %0t: way %0d pc %h lo %h up %h u %b, want %h %h %h %b",
                                         $time, w, ways[w].pc, ways[w].lower, ways[w].upper,
                                         ways[w].uncomp, e.pc, e.lower, e.upper, e.uncomp);
                                mismatch_count++;
                            end
                        end
                    end
                end
            end
        end else begin
            held = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- tests/istream_tb.sv
// runs from the project root; reads tests/istream_cases.txt and assumes INIT_PC 0x8000_0000
`timescale 1ns/1ns
`default_nettype none

module istream_tb;
    import istream_pkg::*;

    logic            CLK;
    logic            nRST;
    logic            valid_senq;
    fetch_set_t      set_senq;
    logic            stall_senq;
    way_t [WAYS-1:0] ways_sdeq;
    logic            valid_sdeq;
    logic            stall_sdeq;
    logic            restart;
    logic [31:0]     restart_pc;

    string       lines[$];
    int          cycles      = 0;
    int          cycle_limit = 0;
    int          stall_until = 0;
    int          bad_lines   = 0;
    int unsigned lcg_state   = 396;

    istream #(
        .ISTREAM_SETS(8),
        .INIT_PC(32'h8000_0000)
    ) uut (
        .CLK(CLK),
        .nRST(nRST),
        .valid_senq(valid_senq),
        .set_senq(set_senq),
        .stall_senq(stall_senq),
        .ways_sdeq(ways_sdeq),
        .valid_sdeq(valid_sdeq),
        .stall_sdeq(stall_sdeq),
        .restart(restart),
        .restart_pc(restart_pc)
    );

    istream_checker chk (
        .CLK(CLK),
        .nRST(nRST),
        .restart(restart),
        .stall_sdeq(stall_sdeq),
        .valid_sdeq(valid_sdeq),
        .ways(ways_sdeq)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // --------------------------------------------------
    // consumer stall, forced windows plus a quarter at random
    initial begin
        stall_sdeq = 1'b0;
        forever begin
            @(negedge CLK);
            stall_sdeq = (cycles < stall_until) || ((lcg_next() >> 30) == 0);
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout, the run did not end within %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic idle_cycle();
        @(negedge CLK);
        valid_senq = 1'b0;
    endtask

    // hold keeps the set on the bus until the buffer takes it
    task automatic present_set(input fetch_set_t fs, input logic hold);
        @(negedge CLK);
        valid_senq = 1'b1;
        set_senq   = fs;
        while (hold && stall_senq) begin
            @(negedge CLK);
        end
    endtask

    task automatic restart_at(input logic [31:0] pc);
        idle_cycle();
        while (chk.pending_count() != 0) begin
            idle_cycle();
        end
        restart    = 1'b1;
        restart_pc = pc;
        @(negedge CLK);
        restart = 1'b0;
    endtask

    task automatic run_line(input string line);
        byte         cmd;
        string       rest;
        logic [31:0] mask;
        logic [31:0] addr;
        logic [31:0] uc;
        logic [15:0] p [8];
        logic [15:0] lo;
        logic [15:0] up;
        int          n;
        int          count;
        fetch_set_t  fs;
        cmd  = line.getc(0);
        rest = line.substr(1, line.len() - 1);
        if (cmd == "E" || cmd == "T") begin
            n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h", mask, p[0], p[1], p[2],
                        p[3], p[4], p[5], p[6], p[7], addr);
            fs.valid      = mask[7:0];
            fs.after_base = addr[31:4];
            for (int i = 0; i < PARCELS_PER_SET; i++) begin
                fs.parcels[i] = p[i];
            end
            if (n == 10) begin
                present_set(fs, cmd == "E");
            end else begin
                bad_lines++;
            end
        end else if (cmd == "X") begin
            n = $sscanf(rest, "%h %h %h %h", addr, lo, up, uc);
            if (n == 4) begin
                chk.push_expected(addr, lo, up, uc[0]);
            end else begin
                bad_lines++;
            end
        end else if (cmd == "W" || cmd == "S") begin
            n = $sscanf(rest, "%d", count);
            if (n != 1) begin
                bad_lines++;
            end else if (cmd == "W") begin
                repeat (count) idle_cycle();
            end else begin
                stall_until = cycles + count;
            end
        end else if (cmd == "R" && $sscanf(rest, "%h", addr) == 1) begin
            restart_at(addr);
        end else begin
            $display("case line not understood: %s", line);
            bad_lines++;
        end
    endtask

    // --------------------------------------------------
    // main sequence
    initial begin
        int    fd;
        int    n;
        int    total;
        string line;
        nRST       = 1'b0;
        valid_senq = 1'b0;
        set_senq   = '0;
        restart    = 1'b0;
        restart_pc = '0;
        fd = $fopen("tests/istream_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/istream_cases.txt, nothing was run");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
            cycle_limit = 20 * lines.size() + 100;
            repeat (3) @(posedge CLK);
            @(negedge CLK);
            nRST = 1'b1;
            foreach (lines[i]) begin
                run_line(lines[i]);
            end
            idle_cycle();
            while (chk.pending_count() != 0) begin
                idle_cycle();
            end
            repeat (20) idle_cycle();
            chk.check_drained();
            total = chk.mismatch_count + chk.extra_count + chk.missing_count + bad_lines;
            $display("errors: %0d mismatched, %0d unexpected, %0d missing, %0d bad lines",
                     chk.mismatch_count, chk.extra_count, chk.missing_count, bad_lines);
            if (total == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tests/istream_cases.txt
# E/T mask p0..p7 after (T is shown one cycle only), W idle, S stall cycles, R restart pc
# X pc lower upper uncomp, expected instructions in program order, all hex
E FF A000 A010 A020 A030 A040 A050 A060 A070 80000010
X 80000000 A000 0000 0
X 80000002 A010 0000 0
X 80000004 A020 0000 0
X 80000006 A030 0000 0
X 80000008 A040 0000 0
X 8000000A A050 0000 0
X 8000000C A060 0000 0
X 8000000E A070 0000 0
E FF B000 B013 B020 B030 B040 B050 B060 B073 80000020
X 80000010 B000 0000 0
X 80000012 B013 B020 1
X 80000016 B030 0000 0
X 80000018 B040 0000 0
X 8000001A B050 0000 0
X 8000001C B060 0000 0
W 6
E FF C001 C010 C023 C030 C040 C050 C060 C070 80000100
X 8000001E B073 C001 1
X 80000022 C010 0000 0
X 80000024 C023 C030 1
X 80000028 C040 0000 0
X 8000002A C050 0000 0
X 8000002C C060 0000 0
X 8000002E C070 0000 0
E F0 DEAD DEAD DEAD DEAD D040 D050 D063 D070 80000120
X 80000108 D040 0000 0
X 8000010A D050 0000 0
X 8000010C D063 D070 1
W 30
S 30
E 01 5000 0000 0000 0000 0000 0000 0000 0000 80000130
X 80000120 5000 0000 0
E 01 5100 0000 0000 0000 0000 0000 0000 0000 80000140
X 80000130 5100 0000 0
E 01 5200 0000 0000 0000 0000 0000 0000 0000 80000150
X 80000140 5200 0000 0
E 01 5300 0000 0000 0000 0000 0000 0000 0000 80000160
X 80000150 5300 0000 0
E 01 5400 0000 0000 0000 0000 0000 0000 0000 80000170
X 80000160 5400 0000 0
E 01 5500 0000 0000 0000 0000 0000 0000 0000 80000180
X 80000170 5500 0000 0
E 01 5600 0000 0000 0000 0000 0000 0000 0000 80000190
X 80000180 5600 0000 0
E 01 5700 0000 0000 0000 0000 0000 0000 0000 800001A0
X 80000190 5700 0000 0
T FF EEE0 EEE0 EEE0 EEE0 EEE0 EEE0 EEE0 EEE0 800001B0
W 40
S 6
E FF 9990 9990 9990 9990 9990 9990 9990 9990 800001B0
R 40000040
E 0F 6000 6010 6023 6030 0000 0000 0000 0000 40000050
X 40000040 6000 0000 0
X 40000042 6010 0000 0
X 40000044 6023 6030 1

//--- istream.f
source/istream_pkg.sv
source/lsb_picker.sv
source/set_store.sv
source/set_tracker.sv
source/way_select.sv
source/istream.sv
tests/istream_checker.sv
tests/istream_tb.sv

//--- Makefile
TOP := istream_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f istream.f --top-module $(TOP)

sim:
	verilator --binary --timing -f istream.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
